// ==== Makefile ====
SIM      = verilator
TOP      = tb_rr_arbiter
FILELIST = rr_arbiter_top.f
VFLAGS   = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/arb_apb_regs.sv ====
/*
 * zero-wait apb slave, pready is tied high
 * CTRL bit 0 enables arbitration, GCNT counts grants and saturates
 * any write to GCNT clears it, unknown addresses give pslverr and zero data
 */

`timescale 1ns/1ps

module arb_apb_regs (
	input  logic               clock_i,
	input  logic               arst_n_i,
	input  arb_pkg::apb_req_t  apb_i,
	output arb_pkg::apb_rsp_t  apb_o,
	input  logic               grant_pulse_i,
	output logic               enable_o
);

	logic           enable_q;
	arb_pkg::cnt_t  cnt_q;

	logic           access;
	logic           wr_en;
	logic           rd_en;
	logic           addr_ok;

	// access phase completes in its own cycle
	assign access  = apb_i.psel && apb_i.penable;
	assign wr_en   = access && apb_i.pwrite;
	assign rd_en   = access && !apb_i.pwrite;
	assign addr_ok = (apb_i.paddr == arb_pkg::ADDR_CTRL) ||
		(apb_i.paddr == arb_pkg::ADDR_GCNT);

	// control register
	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			enable_q <= 1'b0;
		end
		else if (wr_en && (apb_i.paddr == arb_pkg::ADDR_CTRL))
		begin
			enable_q <= apb_i.pwdata[0];
		end
	end

	// grant counter, a clearing write wins over a pulse in the same cycle
	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			cnt_q <= '0;
		end
		else if (wr_en && (apb_i.paddr == arb_pkg::ADDR_GCNT))
		begin
			cnt_q <= '0;
		end
		else if (grant_pulse_i && (cnt_q != '1))
		begin
			cnt_q <= cnt_q + arb_pkg::cnt_t'(1);
		end
	end

	// read mux, quiet outside a read access
	always_comb
	begin
		apb_o = '0;
		apb_o.pready = 1'b1;
		apb_o.pslverr = access && !addr_ok;
		if (rd_en)
		begin
			if (apb_i.paddr == arb_pkg::ADDR_CTRL)
			begin
				apb_o.prdata[0] = enable_q;
			end
			else if (apb_i.paddr == arb_pkg::ADDR_GCNT)
			begin
				apb_o.prdata = cnt_q;
			end
		end
	end

	assign enable_o = enable_q;

	// master protocol, access phase needs a selected slave
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		apb_i.penable |-> apb_i.psel)
		else $error("penable high without psel");

endmodule

// ==== hdl/arb_pkg.sv ====
/*
 * shared widths, types and register map for the 16-line arbiter
 * the split into two groups of 8 is fixed, so these are not module parameters
 */

package arb_pkg;

	// requester count and group split
	localparam int NUM_REQ  = 16;
	localparam int GRP_SIZE = 8;
	localparam int SEL_W    = 4;
	localparam int GSEL_W   = 3;
	localparam int CNT_W    = 32;

	// apb bus widths
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// register map, byte addresses
	localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_GCNT = 8'h04;

	typedef logic [NUM_REQ-1:0]  req_vec_t;
	typedef logic [GRP_SIZE-1:0] grp_vec_t;
	typedef logic [SEL_W-1:0]    sel_t;
	typedef logic [GSEL_W-1:0]   gsel_t;
	typedef logic [CNT_W-1:0]    cnt_t;

	// master to slave
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	// slave to master
	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// winner of one group, combinational
	typedef struct packed {
		logic     any;
		gsel_t    idx;
		grp_vec_t onehot;
	} grp_result_t;

	typedef enum logic {
		IDLE,
		HOLD
	} hold_state_e;

endpackage

// ==== hdl/grant_combine.sv ====
/*
 * picks between the two group winners with alternating priority
 * a grant is held while its request line stays high, then one idle cycle follows
 * enable only gates new grants, a held grant runs until release
 */

`timescale 1ns/1ps

module grant_combine (
	input  logic                  clock_i,
	input  logic                  arst_n_i,
	input  arb_pkg::grp_result_t  grp0_i,
	input  arb_pkg::grp_result_t  grp1_i,
	input  arb_pkg::req_vec_t     req_i,
	input  logic                  enable_i,
	output logic [1:0]            advance_o,
	output logic                  grant_pulse_o,
	output arb_pkg::req_vec_t     grant_o,
	output arb_pkg::sel_t         select_o,
	output logic                  valid_o
);

	arb_pkg::hold_state_e  state_q;
	// group that won last, reset to 1 so group 0 is preferred first
	logic                  last_grp_q;

	logic                  pick_grp;
	arb_pkg::grp_result_t  pick;
	arb_pkg::req_vec_t     onehot_full;
	logic                  take;
	logic                  release_hold;

	always_comb
	begin
		// with both groups requesting, take the one that did not win last
		if (grp0_i.any && grp1_i.any)
		begin
			pick_grp = ~last_grp_q;
		end
		else
		begin
			pick_grp = grp1_i.any;
		end
		pick = pick_grp ? grp1_i : grp0_i;

		// place the group one-hot into its half of the full vector
		onehot_full = '0;
		if (pick_grp)
		begin
			onehot_full[arb_pkg::NUM_REQ-1:arb_pkg::GRP_SIZE] = pick.onehot;
		end
		else
		begin
			onehot_full[arb_pkg::GRP_SIZE-1:0] = pick.onehot;
		end

		take = (state_q == arb_pkg::IDLE) && enable_i && (grp0_i.any || grp1_i.any);
		// select doubles as the full-vector index of the held line
		release_hold = (state_q == arb_pkg::HOLD) && !req_i[select_o];
	end

	// pointer moves in the same cycle the grant is taken
	assign advance_o     = {take && pick_grp, take && !pick_grp};
	assign grant_pulse_o = take;

	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q    <= arb_pkg::IDLE;
			last_grp_q <= 1'b1;
			grant_o    <= '0;
			select_o   <= '0;
			valid_o    <= 1'b0;
		end
		else
		begin
			case (state_q)
				arb_pkg::IDLE:
				begin
					if (take)
					begin
						state_q    <= arb_pkg::HOLD;
						last_grp_q <= pick_grp;
						grant_o    <= onehot_full;
						// group bit on top of the in-group index
						select_o   <= {pick_grp, pick.idx};
						valid_o    <= 1'b1;
					end
				end
				arb_pkg::HOLD:
				begin
					// requester let go, drop outputs and rest one cycle
					if (release_hold)
					begin
						state_q  <= arb_pkg::IDLE;
						grant_o  <= '0;
						select_o <= '0;
						valid_o  <= 1'b0;
					end
				end
				default:
				begin
					state_q <= arb_pkg::IDLE;
				end
			endcase
		end
	end

	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		valid_o |-> $onehot(grant_o))
		else $error("valid grant is not one-hot");

	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		valid_o |-> grant_o[select_o])
		else $error("select does not point at granted line");

	// the grant was registered from, or held by, last cycle's requests
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		(grant_o & ~$past(req_i)) == '0)
		else $error("grant on a line that was not requesting");

endmodule

// ==== hdl/group_rr_arb.sv ====
/*
 * round-robin pick over one group of 8 request lines
 * result is combinational from req_i and the pointer
 * pointer only moves when the combiner pulses advance_i
 */

`timescale 1ns/1ps

module group_rr_arb (
	input  logic                  clock_i,
	input  logic                  arst_n_i,
	input  arb_pkg::grp_vec_t     req_i,
	input  logic                  advance_i,
	output arb_pkg::grp_result_t  result_o
);

	// rotating priority pointer, the line it points at has top priority
	arb_pkg::gsel_t ptr_q;

	// search from the pointer upward and wrap around
	always_comb
	begin
		arb_pkg::gsel_t cand;
		logic           found;

		result_o = '0;
		found    = 1'b0;
		for (int i = 0; i < arb_pkg::GRP_SIZE; i++)
		begin
			// 3-bit add wraps past line 7 back to line 0
			cand = ptr_q + arb_pkg::gsel_t'(i);
			if (!found && req_i[cand])
			begin
				found                   = 1'b1;
				result_o.idx            = cand;
				result_o.onehot[cand]   = 1'b1;
			end
		end
		result_o.any = found;
	end

	// move just past the line that was granted
	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ptr_q <= '0;
		end
		else if (advance_i)
		begin
			ptr_q <= result_o.idx + arb_pkg::gsel_t'(1);
		end
	end

	// winner is a single requesting line or nothing
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		$onehot0(result_o.onehot) && ((result_o.onehot & ~req_i) == '0))
		else $error("group winner not one-hot or not requesting");

	// the combiner must not advance a group that has no winner
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		advance_i |-> result_o.any)
		else $error("advance pulse with empty group");

endmodule

// ==== hdl/rr_arbiter_top.sv ====
/*
 * 16-line round-robin arbiter, two groups of 8 plus apb control
 * arbitration is off after reset until CTRL bit 0 is written
 */

`timescale 1ns/1ps

module rr_arbiter_top (
	input  logic               clock_i,
	input  logic               arst_n_i,
	input  arb_pkg::req_vec_t  req_i,
	input  arb_pkg::apb_req_t  apb_i,
	output arb_pkg::apb_rsp_t  apb_o,
	output arb_pkg::req_vec_t  grant_o,
	output arb_pkg::sel_t      select_o,
	output logic               valid_o
);

	arb_pkg::grp_result_t  grp0_res;
	arb_pkg::grp_result_t  grp1_res;
	logic [1:0]            advance;
	logic                  grant_pulse;
	logic                  enable;

	// lines 7..0
	group_rr_arb u_grp0 (
		.clock_i   (clock_i),
		.arst_n_i  (arst_n_i),
		.req_i     (req_i[arb_pkg::GRP_SIZE-1:0]),
		.advance_i (advance[0]),
		.result_o  (grp0_res)
	);

	// lines 15..8
	group_rr_arb u_grp1 (
		.clock_i   (clock_i),
		.arst_n_i  (arst_n_i),
		.req_i     (req_i[arb_pkg::NUM_REQ-1:arb_pkg::GRP_SIZE]),
		.advance_i (advance[1]),
		.result_o  (grp1_res)
	);

	grant_combine u_combine (
		.clock_i       (clock_i),
		.arst_n_i      (arst_n_i),
		.grp0_i        (grp0_res),
		.grp1_i        (grp1_res),
		.req_i         (req_i),
		.enable_i      (enable),
		.advance_o     (advance),
		.grant_pulse_o (grant_pulse),
		.grant_o       (grant_o),
		.select_o      (select_o),
		.valid_o       (valid_o)
	);

	arb_apb_regs u_regs (
		.clock_i       (clock_i),
		.arst_n_i      (arst_n_i),
		.apb_i         (apb_i),
		.apb_o         (apb_o),
		.grant_pulse_i (grant_pulse),
		.enable_o      (enable)
	);

endmodule

// ==== rr_arbiter_top.f ====
hdl/arb_pkg.sv
hdl/group_rr_arb.sv
hdl/grant_combine.sv
hdl/arb_apb_regs.sv
hdl/rr_arbiter_top.sv
sim/tb_clock_gen.sv
sim/tb_rr_arbiter.sv

// ==== sim/tb_clock_gen.sv ====
/*
 * free-running clock with a 4 ns period
 * reset is held low for 10 rising edges and released on a falling edge
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock_o,
	output logic arst_n_o
);

	localparam int HALF_NS    = 2;
	localparam int RST_CYCLES = 10;

	initial
	begin
		clock_o = 1'b0;
		forever
		begin
			#HALF_NS clock_o = ~clock_o;
		end
	end

	// release away from the rising edge the DUT samples on
	initial
	begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clock_o);
		@(negedge clock_o);
		arst_n_o = 1'b1;
	end

endmodule

// ==== sim/tb_rr_arbiter.sv ====
/*
 * table-driven testbench for the 16-line round-robin arbiter
 * inputs change on the falling edge, outputs are checked on the falling edge
 * a reference model predicts every grant, requesters hold until the bench releases
 */

`timescale 1ns/1ps

module tb_rr_arbiter;

	localparam int ROWS       = 10;
	localparam int CLK_NS     = 4;
	localparam int RST_CYCLES = 10;
	// rows times 16 grants times 8 cycles, plus reset
	localparam int WD_CYCLES  = ROWS * 16 * 8 + RST_CYCLES;

	// drop grants each line once
	// temp lets a granted line rest one cycle and ask again
	// refill applies the vector twice
	typedef enum logic [1:0] {
		M_DROP,
		M_TEMP,
		M_REFILL
	} mode_e;

	typedef struct packed {
		arb_pkg::req_vec_t req;
		logic              en;
		mode_e             mode;
	} row_t;

	row_t rows [ROWS] = '{
		'{16'hFFFF, 1'b0, M_DROP},
		'{16'hFFFF, 1'b1, M_DROP},
		'{16'h8181, 1'b1, M_DROP},
		'{16'h00F0, 1'b1, M_DROP},
		'{16'h0F00, 1'b1, M_TEMP},
		'{16'hA5A5, 1'b1, M_TEMP},
		'{16'h0001, 1'b1, M_REFILL},
		'{16'h3C3C, 1'b1, M_REFILL},
		'{16'hFFFF, 1'b1, M_TEMP},
		'{16'h1248, 1'b0, M_REFILL}
	};

	logic               clock;
	logic               arst_n;
	arb_pkg::req_vec_t  req;
	arb_pkg::apb_req_t  apb;
	arb_pkg::apb_rsp_t  apb_rsp;
	arb_pkg::req_vec_t  grant;
	arb_pkg::sel_t      select;
	logic               valid;

	// reference model state
	int   mdl_ptr [2];
	logic mdl_last;
	int   mdl_grants;

	// grants still owed to each line in the current row
	int   left [arb_pkg::NUM_REQ];

	int   err_cnt;
	int   pass_cnt;
	int   fail_cnt;

	tb_clock_gen u_clock_gen (
		.clock_o  (clock),
		.arst_n_o (arst_n)
	);

	rr_arbiter_top u_rr_arbiter_top (
		.clock_i  (clock),
		.arst_n_i (arst_n),
		.req_i    (req),
		.apb_i    (apb),
		.apb_o    (apb_rsp),
		.grant_o  (grant),
		.select_o (select),
		.valid_o  (valid)
	);

	task automatic check_grant(input string name, input arb_pkg::req_vec_t exp,
		input arb_pkg::req_vec_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_select(input string name, input arb_pkg::sel_t exp,
		input arb_pkg::sel_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string name, input arb_pkg::cnt_t exp,
		input arb_pkg::cnt_t act);
		if (act !== exp)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	// one apb transfer, called on a falling edge, returns on a falling edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		apb.psel    = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite  = wr;
		apb.paddr   = addr;
		apb.pwdata  = wdata;
		@(negedge clock);
		apb.penable = 1'b1;
		// sample mid low phase, well before the completing rising edge
		#1;
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		// zero-wait slave completes every access in one cycle
		check_flag("pready", 1'b1, apb_rsp.pready);
		@(negedge clock);
		apb = '0;
	endtask

	// winner per group from its pointer, then the group not granted last
	task automatic model_pick(input arb_pkg::req_vec_t r, output arb_pkg::req_vec_t g,
		output arb_pkg::sel_t s);
		int win [2];
		int grp;
		int line;
		win[0] = -1;
		win[1] = -1;
		for (int k = 0; k < 2; k++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				line = (mdl_ptr[k] + i) % 8;
				if (win[k] < 0 && r[k * 8 + line])
				begin
					win[k] = line;
				end
			end
		end
		if (win[0] >= 0 && win[1] >= 0)
		begin
			grp = mdl_last ? 0 : 1;
		end
		else
		begin
			grp = (win[1] >= 0) ? 1 : 0;
		end
		g = '0;
		g[grp * 8 + win[grp]] = 1'b1;
		s = arb_pkg::sel_t'(grp * 8 + win[grp]);
		mdl_ptr[grp] = (win[grp] + 1) % 8;
		mdl_last = grp[0];
		mdl_grants++;
	endtask

	function automatic arb_pkg::req_vec_t pending_vec();
		arb_pkg::req_vec_t v;
		v = '0;
		for (int i = 0; i < arb_pkg::NUM_REQ; i++)
		begin
			v[i] = (left[i] > 0);
		end
		return v;
	endfunction

	task automatic run_row(input int r);
		int want [arb_pkg::NUM_REQ];
		int got [arb_pkg::NUM_REQ];
		int per_line;
		int hold;
		bit refilled;
		arb_pkg::req_vec_t exp_g;
		arb_pkg::sel_t exp_s;
		logic [31:0] rdata;
		logic err;
		per_line = !rows[r].en ? 0 : ((rows[r].mode == M_DROP) ? 1 : 2);
		refilled = (rows[r].mode != M_REFILL);
		for (int i = 0; i < arb_pkg::NUM_REQ; i++)
		begin
			want[i] = rows[r].req[i] ? per_line : 0;
			got[i]  = 0;
			left[i] = (rows[r].mode == M_TEMP) ? want[i] : (rows[r].req[i] ? 1 : 0);
		end
		apb_xfer(1'b1, arb_pkg::ADDR_CTRL, {31'b0, rows[r].en}, rdata, err);
		if (!rows[r].en)
		begin
			// disabled arbiter must ignore every request
			req = rows[r].req;
			repeat (4)
			begin
				@(negedge clock);
				check_flag("valid_o", 1'b0, valid);
				check_grant("grant_o", '0, grant);
			end
			req = '0;
		end
		else
		begin
			while (pending_vec() != '0)
			begin
				req = pending_vec();
				model_pick(req, exp_g, exp_s);
				// grant one cycle after the request is seen in IDLE
				@(negedge clock);
				check_flag("valid_o", 1'b1, valid);
				check_grant("grant_o", exp_g, grant);
				check_select("select_o", exp_s, select);
				// tally the line the DUT actually granted
				if (valid)
				begin
					got[select]++;
				end
				hold = $urandom_range(2, 1);
				repeat (hold)
				begin
					@(negedge clock);
					check_grant("grant_o", exp_g, grant);
				end
				left[exp_s]--;
				req[exp_s] = 1'b0;
				@(negedge clock);
				check_flag("valid_o", 1'b0, valid);
				if (!refilled && pending_vec() == '0)
				begin
					refilled = 1'b1;
					for (int i = 0; i < arb_pkg::NUM_REQ; i++)
					begin
						left[i] = rows[r].req[i] ? 1 : 0;
					end
				end
			end
		end
		for (int i = 0; i < arb_pkg::NUM_REQ; i++)
		begin
			check_count($sformatf("grants of line %0d", i), arb_pkg::cnt_t'(want[i]),
				arb_pkg::cnt_t'(got[i]));
		end
		apb_xfer(1'b0, arb_pkg::ADDR_GCNT, 32'h0, rdata, err);
		check_count("GCNT", arb_pkg::cnt_t'(mdl_grants), rdata);
		check_flag("pslverr", 1'b0, err);
	endtask

	task automatic report(input string name, input int errs_before);
		if (err_cnt == errs_before)
		begin
			pass_cnt++;
			$display("%s: pass", name);
		end
		else
		begin
			fail_cnt++;
			$display("%s: FAIL, %0d mismatches", name, err_cnt - errs_before);
		end
	endtask

	initial
	begin
		int errs_before;
		logic [31:0] rdata;
		logic err;
		req        = '0;
		apb        = '0;
		mdl_ptr[0] = 0;
		mdl_ptr[1] = 0;
		// group 0 is preferred first
		mdl_last   = 1'b1;
		mdl_grants = 0;
		err_cnt    = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		void'($urandom(32'h64e4));
		@(posedge arst_n);
		@(negedge clock);

		errs_before = err_cnt;
		check_flag("valid_o", 1'b0, valid);
		check_grant("grant_o", '0, grant);
		apb_xfer(1'b0, arb_pkg::ADDR_CTRL, 32'h0, rdata, err);
		check_count("CTRL", '0, rdata);
		apb_xfer(1'b0, arb_pkg::ADDR_GCNT, 32'h0, rdata, err);
		check_count("GCNT", '0, rdata);
		report("reset values", errs_before);

		for (int r = 0; r < ROWS; r++)
		begin
			errs_before = err_cnt;
			run_row(r);
			report($sformatf("row %0d req %h en %0d mode %s", r, rows[r].req, rows[r].en,
				rows[r].mode.name()), errs_before);
		end

		// counter clear and error response on an unmapped address
		errs_before = err_cnt;
		apb_xfer(1'b1, arb_pkg::ADDR_GCNT, 32'h1234, rdata, err);
		apb_xfer(1'b0, arb_pkg::ADDR_GCNT, 32'h0, rdata, err);
		check_count("GCNT", '0, rdata);
		apb_xfer(1'b0, 8'h08, 32'h0, rdata, err);
		check_flag("pslverr", 1'b1, err);
		check_count("prdata", '0, rdata);
		report("register clear and pslverr", errs_before);

		$display("tests passed %0d failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial
	begin
		#(WD_CYCLES * CLK_NS);
		$display("watchdog expired, the test rows did not finish in time");
		$display("Done: errors found");
		$finish;
	end

endmodule
